//--- logic/fe_buf.sv
`timescale 1ns/1ps
`default_nettype none

module fe_buf
    import fetch_pkg::*;
#(
    parameter int IMEM_WORDS = 128,               // memory depth in words.
    parameter int FB_DEPTH   = 4                  // queue entries.
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          fe_req_valid,
    input  logic [XLEN-1:0]               fe_req_pc,
    input  logic [EPOCH_W-1:0]            fe_req_epoch,
    input  logic [EPOCH_W-1:0]            cur_epoch,
    output logic                          fb_ready,

    output logic                          ic_req_valid,
    output logic [$clog2(IMEM_WORDS)-1:0] ic_req_addr,
    input  logic                          ic_rsp_valid,
    input  logic [XLEN-1:0]               ic_rsp_data,

    input  logic                          decode_ready_de0,
    output logic                          valid_fe1,
    output logic [XLEN-1:0]               instr_fe1,
    output logic [XLEN-1:0]               pc_fe1
);

    localparam int IDX_W = $clog2(IMEM_WORDS);
    localparam int PTR_W = $clog2(FB_DEPTH);
    localparam int CNT_W = $clog2(FB_DEPTH + 1);
    localparam int OCC_W = CNT_W + 1;             // queue plus two in flight.

    // in-flight record, one stage per memory stage.
    logic               s1_vld, s2_vld;
    logic [XLEN-1:0]    s1_pc, s2_pc;
    logic [EPOCH_W-1:0] s1_ep, s2_ep;

    // instruction queue.
    logic [XLEN-1:0]    q_instr [FB_DEPTH];
    logic [XLEN-1:0]    q_pc    [FB_DEPTH];
    logic [EPOCH_W-1:0] q_ep    [FB_DEPTH];
    logic [PTR_W-1:0]   wr_ptr, rd_ptr;
    logic [CNT_W-1:0]   q_count;

    logic               push, pop;
    logic               head_vld, head_cur;
    logic [OCC_W-1:0]   occupancy;

    // slots already promised plus slots in use.
    assign occupancy = OCC_W'(q_count) + OCC_W'(s1_vld) + OCC_W'(s2_vld);
    assign fb_ready  = occupancy < OCC_W'(FB_DEPTH);

    assign ic_req_valid = fe_req_valid & fb_ready;
    assign ic_req_addr  = fe_req_pc[WORD_LSB +: IDX_W];  // wraps modulo depth.

    // shift record, matches the two-cycle memory.
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
        end else begin
            s1_vld <= ic_req_valid;
            s2_vld <= s1_vld;
        end
        s1_pc <= fe_req_pc;
        s1_ep <= fe_req_epoch;
        s2_pc <= s1_pc;
        s2_ep <= s1_ep;
    end

    assign head_vld = (q_count != '0);
    assign head_cur = (q_ep[rd_ptr] == cur_epoch);

    // stale responses never enter.
    assign push = ic_rsp_valid & (s2_ep == cur_epoch);
    // stale head drains without decode.
    assign pop  = head_vld & (~head_cur | decode_ready_de0);

    always_ff @(posedge clk) begin
        if (push) begin
            q_instr[wr_ptr] <= ic_rsp_data;
            q_pc[wr_ptr]    <= s2_pc;
            q_ep[wr_ptr]    <= s2_ep;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
        end
    end

    // head goes straight to decode.
    assign valid_fe1 = head_vld & head_cur;
    assign instr_fe1 = q_instr[rd_ptr];
    assign pc_fe1    = q_pc[rd_ptr];

    // memory must only answer what was asked two cycles back.
    a_rsp_tracked: assert property (@(posedge clk) disable iff (rst)
        ic_rsp_valid |-> s2_vld)
        else $error("fe_buf: response with no in-flight record");

    // a stalled head holds unless a redirect kills it.
    a_hold_stall: assert property (@(posedge clk) disable iff (rst)
        (valid_fe1 && !decode_ready_de0) ##1 (cur_epoch == $past(cur_epoch))
        |-> valid_fe1 && $stable(instr_fe1) && $stable(pc_fe1))
        else $error("fe_buf: decode output changed under stall");

endmodule

`default_nettype wire

//--- logic/fe_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module fe_ctl
    import fetch_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0      // first fetch address.
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               br_mispred_valid,  // execute redirect.
    input  logic [XLEN-1:0]    br_mispred_target,
    input  logic               nuke_valid,        // retire redirect, halts fetch.
    input  logic [XLEN-1:0]    nuke_target,
    input  logic               resume_fetch,      // leaves halt.

    input  logic               fb_ready,          // buffer has a free slot.
    output logic               fe_req_valid,
    output logic [XLEN-1:0]    fe_req_pc,
    output logic [EPOCH_W-1:0] fe_req_epoch,
    output logic [EPOCH_W-1:0] cur_epoch
);

    t_fe_state          state;                    // run/halt.
    logic [XLEN-1:0]    pc;                       // next fetch address.
    logic [EPOCH_W-1:0] epoch;                    // bumps on every redirect.

    logic               redirect;                 // any redirect this cycle.
    logic [XLEN-1:0]    redirect_pc;              // chosen redirect target.
    logic               req_fire;                 // request taken by buffer.

    // nuke wins over a same-cycle mispredict.
    always_comb begin
        redirect    = nuke_valid | br_mispred_valid;
        redirect_pc = nuke_valid ? nuke_target : br_mispred_target;
    end

    // no request in a redirect cycle, its pc is already dead.
    assign fe_req_valid = (state == FE_RUN) & ~redirect;
    assign fe_req_pc    = pc;
    assign fe_req_epoch = epoch;
    assign cur_epoch    = epoch;                  // buffer filters on this.

    assign req_fire = fe_req_valid & fb_ready;

    // pc register.
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirect_pc;                    // restart at target.
        end else if (req_fire) begin
            pc <= pc + XLEN'(PC_STEP);            // sequential path.
        end
    end

    // epoch counter, wraps freely.
    always_ff @(posedge clk) begin
        if (rst) begin
            epoch <= '0;
        end else if (redirect) begin
            epoch <= epoch + EPOCH_W'(1);
        end
    end

    // run/halt FSM.
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FE_RUN;
        end else begin
            case (state)
                FE_RUN: begin
                    if (nuke_valid) begin
                        state <= FE_HALT;         // wait for retire to release.
                    end
                end
                FE_HALT: begin
                    if (resume_fetch && !nuke_valid) begin
                        state <= FE_RUN;
                    end
                end
                default: begin
                    state <= FE_RUN;
                end
            endcase
        end
    end

    // after a nuke nothing is requested until retire lets go.
    a_halt_no_req: assert property (@(posedge clk) disable iff (rst)
        nuke_valid |=> (!fe_req_valid until resume_fetch))
        else $error("fe_ctl: request issued while halted after nuke");

    // redirect targets and reset pc must keep fetch word aligned.
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        fe_req_valid |-> (fe_req_pc[WORD_LSB-1:0] == '0))
        else $error("fe_ctl: unaligned fetch pc %h", fe_req_pc);

endmodule

`default_nettype wire

//--- logic/fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fetch
    import fetch_pkg::*;
#(
    parameter int              IMEM_WORDS = 128,
    parameter int              FB_DEPTH   = 4,
    parameter logic [XLEN-1:0] RESET_PC   = '0
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          br_mispred_valid,
    input  logic [XLEN-1:0]               br_mispred_target,
    input  logic                          nuke_valid,
    input  logic [XLEN-1:0]               nuke_target,
    input  logic                          resume_fetch,

    output logic                          ic_req_valid,
    output logic [$clog2(IMEM_WORDS)-1:0] ic_req_addr,
    input  logic                          ic_rsp_valid,
    input  logic [XLEN-1:0]               ic_rsp_data,

    input  logic                          decode_ready_de0,
    output logic                          valid_fe1,
    output logic [XLEN-1:0]               instr_fe1,
    output logic [XLEN-1:0]               pc_fe1
);

    logic               fe_req_valid;             // ctl to buffer request.
    logic [XLEN-1:0]    fe_req_pc;
    logic [EPOCH_W-1:0] fe_req_epoch;
    logic [EPOCH_W-1:0] cur_epoch;                // live epoch for filtering.
    logic               fb_ready;

    fe_ctl #(
        .RESET_PC (RESET_PC)
    ) fe_ctl (
        .clk,
        .rst,
        .br_mispred_valid,
        .br_mispred_target,
        .nuke_valid,
        .nuke_target,
        .resume_fetch,
        .fb_ready,
        .fe_req_valid,
        .fe_req_pc,
        .fe_req_epoch,
        .cur_epoch
    );

    fe_buf #(
        .IMEM_WORDS (IMEM_WORDS),
        .FB_DEPTH   (FB_DEPTH)
    ) fe_buf (
        .clk,
        .rst,
        .fe_req_valid,
        .fe_req_pc,
        .fe_req_epoch,
        .cur_epoch,
        .fb_ready,
        .ic_req_valid,
        .ic_req_addr,
        .ic_rsp_valid,
        .ic_rsp_data,
        .decode_ready_de0,
        .valid_fe1,
        .instr_fe1,
        .pc_fe1
    );

endmodule

`default_nettype wire

//--- logic/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // core widths.
    localparam int XLEN    = 32;                  // data and pc width.
    localparam int EPOCH_W = 2;                   // redirect epoch tag width.

    // instruction word geometry.
    localparam int WORD_LSB = 2;                  // byte offset bits in a pc.
    localparam int PC_STEP  = 4;                  // bytes per sequential fetch.

    // run/halt state of the pc generator.
    typedef enum logic {
        FE_RUN  = 1'b0,                           // issuing sequential requests.
        FE_HALT = 1'b1                            // parked after a nuke.
    } t_fe_state;

    // stimulus opcodes for the testbench table.
    typedef enum logic [2:0] {
        OP_LOAD     = 3'd0,                       // preload memory words.
        OP_RUN      = 3'd1,                       // fetch with decode always ready.
        OP_MISPRED  = 3'd2,                       // branch mispredict pulse.
        OP_NUKE     = 3'd3,                       // retire nuke pulse.
        OP_RESUME   = 3'd4,                       // resume after nuke.
        OP_STALLRUN = 3'd5                        // fetch with random decode stalls.
    } t_tb_op;

endpackage

`default_nettype wire

//--- logic/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top
    import fetch_pkg::*;
#(
    parameter int              IMEM_WORDS = 128,  // power of two.
    parameter int              FB_DEPTH   = 4,    // two or more.
    parameter logic [XLEN-1:0] RESET_PC   = '0    // word aligned.
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          load_en,
    input  logic [$clog2(IMEM_WORDS)-1:0] load_addr,
    input  logic [XLEN-1:0]               load_data,

    input  logic                          br_mispred_valid,
    input  logic [XLEN-1:0]               br_mispred_target,
    input  logic                          nuke_valid,
    input  logic [XLEN-1:0]               nuke_target,
    input  logic                          resume_fetch,

    input  logic                          decode_ready_de0,
    output logic                          valid_fe1,
    output logic [XLEN-1:0]               instr_fe1,
    output logic [XLEN-1:0]               pc_fe1
);

    logic                          ic_req_valid;  // fetch to memory.
    logic [$clog2(IMEM_WORDS)-1:0] ic_req_addr;
    logic                          ic_rsp_valid;  // memory to fetch.
    logic [XLEN-1:0]               ic_rsp_data;

    fetch #(
        .IMEM_WORDS (IMEM_WORDS),
        .FB_DEPTH   (FB_DEPTH),
        .RESET_PC   (RESET_PC)
    ) fetch (
        .clk,
        .rst,
        .br_mispred_valid,
        .br_mispred_target,
        .nuke_valid,
        .nuke_target,
        .resume_fetch,
        .ic_req_valid,
        .ic_req_addr,
        .ic_rsp_valid,
        .ic_rsp_data,
        .decode_ready_de0,
        .valid_fe1,
        .instr_fe1,
        .pc_fe1
    );

    imem #(
        .IMEM_WORDS (IMEM_WORDS)
    ) imem (
        .clk,
        .rst,
        .load_en,
        .load_addr,
        .load_data,
        .ic_req_valid,
        .ic_req_addr,
        .ic_rsp_valid,
        .ic_rsp_data
    );

endmodule

`default_nettype wire

//--- logic/imem.sv
`timescale 1ns/1ps
`default_nettype none

module imem
    import fetch_pkg::*;
#(
    parameter int IMEM_WORDS = 128                // depth, power of two.
) (
    input  logic                          clk,
    input  logic                          rst,

    // preload port.
    input  logic                          load_en,
    input  logic [$clog2(IMEM_WORDS)-1:0] load_addr,
    input  logic [XLEN-1:0]               load_data,

    // fetch read port.
    input  logic                          ic_req_valid,
    input  logic [$clog2(IMEM_WORDS)-1:0] ic_req_addr,
    output logic                          ic_rsp_valid,
    output logic [XLEN-1:0]               ic_rsp_data
);

    localparam int IDX_W = $clog2(IMEM_WORDS);

    logic [XLEN-1:0]  mem [IMEM_WORDS];           // word storage.

    logic             rd_vld;                     // stage one valid.
    logic [IDX_W-1:0] rd_addr;                    // stage one address.

    // preload writes.
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // stage one captures the request.
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= ic_req_valid;
        end
        rd_addr <= ic_req_addr;
    end

    // stage two reads the array into the data register.
    always_ff @(posedge clk) begin
        if (rst) begin
            ic_rsp_valid <= 1'b0;
        end else begin
            ic_rsp_valid <= rd_vld;
        end
        ic_rsp_data <= mem[rd_addr];             // no bubble, one read per cycle.
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+verification
logic/fetch_pkg.sv
logic/fe_ctl.sv
logic/fe_buf.sv
logic/imem.sv
logic/fetch.sv
logic/fetch_top.sv
verification/fetch_tb.sv

//--- verification/fetch_tb_table.svh
`ifndef FETCH_TB_TABLE_SVH
`define FETCH_TB_TABLE_SVH

// one step of the test, applied in order.
typedef struct packed {
    t_tb_op      op;                              // what to do.
    logic [31:0] arg;                             // load key or redirect target.
    logic [15:0] count;                           // words, deliveries or quiet cycles.
} t_row;

localparam int N_ROWS = 14;

// op           arg            count
t_row rows [N_ROWS] = '{
    '{OP_LOAD,     32'h6D2B_0000, 16'd128},      // fill every word, restart at reset pc.
    '{OP_RUN,      32'h0000_0000, 16'd24},       // plain sequential stream.
    '{OP_STALLRUN, 32'h0000_0000, 16'd40},       // buffer fills under stalls.
    '{OP_MISPRED,  32'h0000_0100, 16'd0},        // jump to word 64.
    '{OP_RUN,      32'h0000_0000, 16'd10},
    '{OP_STALLRUN, 32'h0000_0000, 16'd16},
    '{OP_NUKE,     32'h0000_0040, 16'd20},       // halt, fetch must stay quiet.
    '{OP_RESUME,   32'h0000_0000, 16'd0},
    '{OP_RUN,      32'h0000_0000, 16'd12},       // restarts at the nuke target.
    '{OP_MISPRED,  32'h0000_01F0, 16'd0},        // four words from the end.
    '{OP_STALLRUN, 32'h0000_0000, 16'd12},       // runs past the top, wraps to 0.
    '{OP_MISPRED,  32'h0000_0300, 16'd0},        // beyond memory, aliases word 64.
    '{OP_MISPRED,  32'h0000_0084, 16'd0},        // second redirect right after.
    '{OP_RUN,      32'h0000_0000, 16'd8}
};

`endif

//--- verification/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb
    import fetch_pkg::*;
();

    localparam int              IMEM_WORDS = 128;
    localparam int              FB_DEPTH   = 4;
    localparam logic [XLEN-1:0] RESET_PC   = '0;
    localparam int              IDX_W      = $clog2(IMEM_WORDS);

    logic               clk = 1'b0;
    logic               rst;
    logic               load_en;
    logic [IDX_W-1:0]   load_addr;
    logic [XLEN-1:0]    load_data;
    logic               br_mispred_valid;
    logic [XLEN-1:0]    br_mispred_target;
    logic               nuke_valid;
    logic [XLEN-1:0]    nuke_target;
    logic               resume_fetch;
    logic               decode_ready_de0;
    logic               valid_fe1;
    logic [XLEN-1:0]    instr_fe1;
    logic [XLEN-1:0]    pc_fe1;

    logic [XLEN-1:0]    mem_model [IMEM_WORDS];   // words as loaded.
    logic [XLEN-1:0]    model_pc;                 // next pc decode should see.
    logic [XLEN-1:0]    exp_instr;
    logic               halted;                   // between nuke and resume.
    logic               held_valid;               // last cycle was a stall.
    logic               held_redirect;            // last cycle had a redirect.
    logic [XLEN-1:0]    held_pc;
    logic [XLEN-1:0]    held_instr;
    logic [31:0]        rnd;
    integer             seed = 32'h7600;
    int                 delivered;                // handshakes seen so far.
    int                 mismatch_errs;
    int                 other_errs;
    int                 cycles = 0;
    int                 cycle_limit;

    `include "fetch_tb_table.svh"

    fetch_top #(
        .IMEM_WORDS (IMEM_WORDS),
        .FB_DEPTH   (FB_DEPTH),
        .RESET_PC   (RESET_PC)
    ) dut (
        .clk,
        .rst,
        .load_en,
        .load_addr,
        .load_data,
        .br_mispred_valid,
        .br_mispred_target,
        .nuke_valid,
        .nuke_target,
        .resume_fetch,
        .decode_ready_de0,
        .valid_fe1,
        .instr_fe1,
        .pc_fe1
    );

    always #4 clk = ~clk;                         // 8 ns period.

    // memory index is the word address modulo depth.
    function automatic logic [IDX_W-1:0] word_index(input logic [XLEN-1:0] pc);
        return IDX_W'((pc >> 2) % XLEN'(IMEM_WORDS));
    endfunction

    // distinct word per address.
    function automatic logic [XLEN-1:0] load_word(input logic [XLEN-1:0] key, input int idx);
        logic [15:0] low;
        low = idx[15:0];
        return key ^ {~low, low};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic redirect_pulse(input logic nuke, input logic [XLEN-1:0] target);
        next_cycle();
        br_mispred_valid  = ~nuke;
        br_mispred_target = target;
        nuke_valid        = nuke;
        nuke_target       = target;
        next_cycle();
        br_mispred_valid = 1'b0;
        nuke_valid       = 1'b0;
    endtask

    // first fetch after reset sits at the queue head while decode is held off.
    task automatic check_reset_fetch();
        while (!valid_fe1) begin
            next_cycle();
        end
        assert (pc_fe1 === RESET_PC) else begin
            $display("MISMATCH pc_fe1 expected %h got %h", RESET_PC, pc_fe1);
            mismatch_errs++;
        end
    endtask

    task automatic preload(input logic [XLEN-1:0] key, input int words);
        decode_ready_de0 = 1'b0;                  // garbage fetched before load waits here.
        for (int i = 0; i < words; i++) begin
            next_cycle();
            load_en      = 1'b1;
            load_addr    = IDX_W'(i);
            load_data    = load_word(key, i);
            mem_model[i] = load_data;
        end
        next_cycle();
        load_en = 1'b0;
        redirect_pulse(1'b0, RESET_PC);           // flush the garbage and restart at reset pc.
    endtask

    task automatic resume_pulse();
        next_cycle();
        resume_fetch = 1'b1;
        next_cycle();
        resume_fetch = 1'b0;
    endtask

    task automatic run_deliveries(input int n, input logic stall);
        int target;
        target = delivered + n;
        while (delivered < target) begin
            next_cycle();
            rnd = $random(seed);
            decode_ready_de0 = stall ? rnd[0] : 1'b1;
        end
    endtask

    task automatic apply_row(input t_row row);
        case (row.op)
            OP_LOAD:     preload(row.arg, int'(row.count));
            OP_RUN:      run_deliveries(int'(row.count), 1'b0);
            OP_STALLRUN: run_deliveries(int'(row.count), 1'b1);
            OP_MISPRED:  redirect_pulse(1'b0, row.arg);
            OP_NUKE: begin
                decode_ready_de0 = 1'b1;
                redirect_pulse(1'b1, row.arg);
                repeat (row.count) next_cycle(); // halted checks run meanwhile.
            end
            OP_RESUME:   resume_pulse();
            default: begin
                $display("table row has an unknown opcode %0d", row.op);
                other_errs++;
            end
        endcase
    endtask

    // reference model and checks on the falling edge.
    always @(negedge clk) begin
        if (!rst) begin
            if (halted) begin
                assert (!valid_fe1) else begin
                    $display("valid_fe1 went high while fetch was halted by a nuke");
                    other_errs++;
                end
            end
            if (held_valid && !held_redirect) begin
                assert (valid_fe1) else begin
                    $display("valid_fe1 dropped while decode was stalling");
                    other_errs++;
                end
                assert (pc_fe1 === held_pc) else begin
                    $display("MISMATCH pc_fe1 held %h now %h", held_pc, pc_fe1);
                    mismatch_errs++;
                end
                assert (instr_fe1 === held_instr) else begin
                    $display("MISMATCH instr_fe1 held %h now %h", held_instr, instr_fe1);
                    mismatch_errs++;
                end
            end
            if (valid_fe1 && decode_ready_de0) begin
                exp_instr = mem_model[word_index(model_pc)];
                assert (pc_fe1 === model_pc) else begin
                    $display("MISMATCH pc_fe1 expected %h got %h", model_pc, pc_fe1);
                    mismatch_errs++;
                end
                assert (instr_fe1 === exp_instr) else begin
                    $display("MISMATCH instr_fe1 expected %h got %h", exp_instr, instr_fe1);
                    mismatch_errs++;
                end
                model_pc = model_pc + 32'd4;
                delivered++;
            end
            held_valid    = valid_fe1 && !decode_ready_de0;
            held_redirect = br_mispred_valid || nuke_valid;
            held_pc       = pc_fe1;
            held_instr    = instr_fe1;
            if (nuke_valid) begin                 // nuke wins over mispredict.
                model_pc = nuke_target;
                halted   = 1'b1;
            end else if (br_mispred_valid) begin
                model_pc = br_mispred_target;
            end
            if (resume_fetch && !nuke_valid) begin
                halted = 1'b0;
            end
        end
    end

    // watchdog.
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout, the table did not finish within %0d cycles", cycle_limit);
            $display("errors: %0d mismatch, %0d other", mismatch_errs, other_errs + 1);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        rst               = 1'b1;
        load_en           = 1'b0;
        load_addr         = '0;
        load_data         = '0;
        br_mispred_valid  = 1'b0;
        br_mispred_target = '0;
        nuke_valid        = 1'b0;
        nuke_target       = '0;
        resume_fetch      = 1'b0;
        decode_ready_de0  = 1'b0;
        model_pc          = RESET_PC;
        halted            = 1'b0;
        held_valid        = 1'b0;
        held_redirect     = 1'b0;
        delivered         = 0;
        mismatch_errs     = 0;
        other_errs        = 0;
        cycle_limit       = 0;
        foreach (rows[r]) begin
            cycle_limit += 40 * int'(rows[r].count);
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        check_reset_fetch();
        foreach (rows[r]) begin
            apply_row(rows[r]);
        end
        repeat (4) next_cycle();                  // let the last handshakes land.
        $display("errors: %0d mismatch, %0d other", mismatch_errs, other_errs);
        if (mismatch_errs + other_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
